// ==== Makefile ====
# Verilator build and run of the translation service testbench

VERILATOR ?= verilator
TOP ?= tb_vtp_svc
FILELIST ?= vtp_svc.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIMFLAGS ?= +verilator+error+limit+1000

FAIL_MSG := Finished with errors
PASS_MSG := Finished with no errors

SRCS := $(shell grep -v '^+' $(FILELIST)) vtp_settings.svh
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS SIMFLAGS"

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM)
	-./$(SIM) $(SIMFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_clk_gen.sv ====
// Testbench clock and synchronous reset generator
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    // Free running clock with a 10 ns period
    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset is held low for ten cycles and released just after an edge
    initial
    begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// ==== tb_vtp_svc.sv ====
// Testbench with host memory model, reference translation, port stimulus and response checks
`timescale 1ns/1ns
`include "vtp_settings.svh"

module tb_vtp_svc;

    typedef struct packed {
        logic [7:0] port;
        vtp_pkg::vpn_t vpn;
        vtp_pkg::ppn_t exp_ppn;
        logic exp_err;
        vtp_pkg::ppn_t got_ppn;
        logic got_err;
    } result_t;

    logic clk;
    logic rst_n;
    logic [`VTP_N_PORTS-1:0] req_valid;
    vtp_pkg::vpn_t req_vpn [`VTP_N_PORTS];
    logic [`VTP_N_PORTS-1:0] busy;
    logic [`VTP_N_PORTS-1:0] rsp_valid;
    vtp_pkg::ppn_t rsp_ppn [`VTP_N_PORTS];
    logic [`VTP_N_PORTS-1:0] rsp_error;
    logic mem_rd_en;
    vtp_pkg::pt_addr_t mem_rd_addr;
    logic mem_rd_valid;
    logic [`VTP_PTE_BITS-1:0] mem_rd_data;
    logic csr_wr_en;
    logic csr_rd_en;
    logic [`VTP_CSR_IDX_BITS-1:0] csr_idx;
    logic [`VTP_CSR_DATA_BITS-1:0] csr_wr_data;
    logic csr_rd_valid;
    logic [`VTP_CSR_DATA_BITS-1:0] csr_rd_data;

    // Sparse host memory, addresses never written read as an invalid entry
    logic [`VTP_PTE_BITS-1:0] mem [vtp_pkg::pt_addr_t];
    vtp_pkg::pt_addr_t root_addr;
    vtp_pkg::pt_addr_t rd_addr;
    int rd_wait;

    // VPNs that the ports pick from, valid ones first and invalid ones last
    vtp_pkg::vpn_t pool [16];
    result_t res_q [$];

    // Bookkeeping for the counter checks
    bit seen [vtp_pkg::vpn_t];
    int distinct_total;
    int invalid_count;
    int l2_count;
    int checks;
    int errors;

    localparam vtp_pkg::pt_addr_t L2_BASE = 32'h0020_0000;

    tb_clk_gen clk_gen_i (
        .clk(clk),
        .rst_n(rst_n)
    );

    vtp_svc dut_i (.*);

    bind vtp_svc vtp_svc_asserts asserts_i (
        .clk(clk),
        .rst_n(rst_n),
        .req_valid(req_valid),
        .busy(busy),
        .rsp_valid(rsp_valid),
        .mem_rd_en(mem_rd_en),
        .mem_rd_valid(mem_rd_valid),
        .csr_rd_en(csr_rd_en),
        .csr_rd_valid(csr_rd_valid)
    );

    function automatic logic [`VTP_PTE_BITS-1:0] mem_word(input vtp_pkg::pt_addr_t a);
        return mem.exists(a) ? mem[a] : '0;
    endfunction

    function automatic logic [`VTP_PTE_BITS-1:0] dir_pte(input vtp_pkg::pt_addr_t next);
        vtp_pkg::pte_u e;
        e = '0;
        e.dir.valid = 1'b1;
        e.dir.next = next;
        return e;
    endfunction

    function automatic logic [`VTP_PTE_BITS-1:0] leaf_pte(input vtp_pkg::ppn_t ppn);
        vtp_pkg::pte_u e;
        e = '0;
        e.leaf.valid = 1'b1;
        e.leaf.leaf = 1'b1;
        e.leaf.ppn = ppn;
        return e;
    endfunction

    // Expected translation, walked directly over the memory model
    function automatic void translate_ref(input vtp_pkg::vpn_t vpn,
                                          output vtp_pkg::ppn_t ppn, output logic err);
        vtp_pkg::pte_u e1;
        vtp_pkg::pte_u e2;
        logic [`VTP_IDX_BITS-1:0] hi;
        logic [`VTP_IDX_BITS-1:0] lo;
        hi = vpn[`VTP_VPN_BITS-1:`VTP_IDX_BITS];
        lo = vpn[`VTP_IDX_BITS-1:0];
        ppn = '0;
        err = 1'b1;
        e1 = mem_word(root_addr + vtp_pkg::pt_addr_t'(hi) * 8);
        if (e1.dir.valid && e1.dir.leaf)
        begin
            // Huge page keeps the upper leaf bits and takes the low index from the VPN
            ppn = {e1.leaf.ppn[`VTP_PPN_BITS-1:`VTP_IDX_BITS], lo};
            err = 1'b0;
        end
        else if (e1.dir.valid)
        begin
            e2 = mem_word(e1.dir.next + vtp_pkg::pt_addr_t'(lo) * 8);
            if (e2.leaf.valid && e2.leaf.leaf)
            begin
                ppn = e2.leaf.ppn;
                err = 1'b0;
            end
        end
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic abort_run(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic csr_write(input logic [`VTP_CSR_IDX_BITS-1:0] idx,
                             input logic [31:0] data);
        @(posedge clk);
        #1;
        csr_wr_en = 1'b1;
        csr_idx = idx;
        csr_wr_data = data;
        @(posedge clk);
        #1;
        csr_wr_en = 1'b0;
    endtask

    task automatic csr_read(input logic [`VTP_CSR_IDX_BITS-1:0] idx,
                            output logic [31:0] data);
        int n;
        @(posedge clk);
        #1;
        csr_rd_en = 1'b1;
        csr_idx = idx;
        n = 0;
        do
        begin
            @(posedge clk);
            #1;
            csr_rd_en = 1'b0;
            n++;
            if (n > 10)
                abort_run("CSR read data");
        end
        while (!csr_rd_valid);
        data = csr_rd_data;
    endtask

    // One client, requests from the pool and queues each result for comparison
    task automatic run_port(input int p, input int count);
        result_t r;
        vtp_pkg::ppn_t exp_ppn;
        logic exp_err;
        int n;
        for (int k = 0; k < count; k++)
        begin
            // At least one idle cycle follows every response
            repeat (1 + $urandom % 3) @(posedge clk);
            #1;
            r.vpn = pool[$urandom % 16];
            translate_ref(r.vpn, exp_ppn, exp_err);
            req_valid[p] = 1'b1;
            req_vpn[p] = r.vpn;
            n = 0;
            do
            begin
                @(posedge clk);
                #1;
                req_valid[p] = 1'b0;
                n++;
                if (n > 1000)
                    abort_run($sformatf("response on port %0d", p));
            end
            while (!rsp_valid[p]);
            r.port = 8'(p);
            r.exp_ppn = exp_ppn;
            r.exp_err = exp_err;
            r.got_ppn = rsp_ppn[p];
            r.got_err = rsp_error[p];
            // A response slower than one cycle went through L2
            if (n > 1)
                l2_count++;
            if (exp_err)
                invalid_count++;
            else if (!seen.exists(r.vpn))
            begin
                seen[r.vpn] = 1'b1;
                distinct_total++;
            end
            res_q.push_back(r);
        end
    endtask

    task automatic drain_results();
        int n;
        n = 0;
        while (res_q.size() > 0)
        begin
            @(posedge clk);
            n++;
            if (n > 100)
                abort_run("result comparison");
        end
    endtask

    // Host memory answers each read after 1 to 6 cycles
    always @(posedge clk)
    begin
        #1;
        mem_rd_valid = 1'b0;
        if (rd_wait > 0)
        begin
            rd_wait--;
            if (rd_wait == 0)
            begin
                mem_rd_valid = 1'b1;
                mem_rd_data = mem_word(rd_addr);
            end
        end
        if (mem_rd_en)
        begin
            rd_addr = mem_rd_addr;
            rd_wait = 1 + $urandom % 6;
        end
    end

    // Compares every queued response with its expected value
    always @(posedge clk)
    begin
        result_t r;
        while (res_q.size() > 0)
        begin
            r = res_q.pop_front();
            check_value($sformatf("port %0d vpn %h error", r.port, r.vpn),
                        32'(r.got_err), 32'(r.exp_err));
            if (!r.exp_err)
                check_value($sformatf("port %0d vpn %h ppn", r.port, r.vpn),
                            32'(r.got_ppn), 32'(r.exp_ppn));
        end
    end

    initial
    begin
        logic [31:0] data;
        logic [31:0] hits;
        logic [31:0] misses;
        int n;
        int afail;
        void'($urandom(32'h542b));
        req_valid = '0;
        for (int p = 0; p < `VTP_N_PORTS; p++)
            req_vpn[p] = '0;
        mem_rd_valid = 1'b0;
        mem_rd_data = '0;
        csr_wr_en = 1'b0;
        csr_rd_en = 1'b0;
        csr_idx = '0;
        csr_wr_data = '0;
        rd_wait = 0;

        // Sixteen directories with 4 KB leaves, every sixteenth leaf left invalid
        root_addr = 32'h0001_0000;
        for (int h = 0; h < 16; h++)
        begin
            mem[root_addr + h * 8] = dir_pte(L2_BASE + h * 32'h800);
            for (int l = 0; l < 256; l++)
                if (l % 16 != 15)
                    mem[L2_BASE + h * 32'h800 + l * 8] = leaf_pte(vtp_pkg::ppn_t'($urandom));
        end
        // Four huge pages directly in the level-1 table
        for (int h = 'h40; h < 'h44; h++)
            mem[root_addr + h * 8] = leaf_pte(vtp_pkg::ppn_t'($urandom));

        for (int i = 0; i < 10; i++)
            pool[i] = {8'($urandom % 16), 4'($urandom), 4'($urandom % 15)};
        pool[10] = {8'(8'h40 + $urandom % 4), 8'($urandom)};
        pool[11] = {8'(8'h40 + $urandom % 4), 8'($urandom)};
        // Invalid at level 1, then invalid at level 2
        pool[12] = {8'h80, 8'($urandom)};
        pool[13] = {8'h9a, 8'($urandom)};
        pool[14] = {8'($urandom % 16), 4'($urandom), 4'hf};
        pool[15] = {8'($urandom % 16), 4'($urandom), 4'hf};

        n = 0;
        while (!rst_n)
        begin
            @(posedge clk);
            n++;
            if (n > 50)
                abort_run("reset release");
        end

        csr_read(`VTP_CSR_ID, data);
        check_value("ID", data, `VTP_ID_VALUE);
        csr_read(`VTP_CSR_HITS, data);
        check_value("HITS after reset", data, 0);
        csr_read(`VTP_CSR_MISSES, data);
        check_value("MISSES after reset", data, 0);
        csr_read(`VTP_CSR_ERRORS, data);
        check_value("ERRORS after reset", data, 0);
        csr_write(`VTP_CSR_ROOT, root_addr);
        csr_read(`VTP_CSR_ROOT, data);
        check_value("ROOT", data, root_addr);

        // Both ports translate concurrently, repeats give L1 and L2 hits
        fork
            run_port(0, 40);
            run_port(1, 40);
        join
        drain_results();

        // Remap every valid pool page, then invalidate the caches while idle
        for (int i = 0; i < 10; i++)
            mem[L2_BASE + pool[i][15:8] * 32'h800 + pool[i][7:0] * 8] =
                leaf_pte(vtp_pkg::ppn_t'($urandom));
        mem[root_addr + pool[10][15:8] * 8] = leaf_pte(vtp_pkg::ppn_t'($urandom));
        mem[root_addr + pool[11][15:8] * 8] = leaf_pte(vtp_pkg::ppn_t'($urandom));
        csr_write(`VTP_CSR_CTRL, 32'h1);
        seen.delete();
        repeat (2) @(posedge clk);

        fork
            run_port(0, 20);
            run_port(1, 20);
        join
        drain_results();

        csr_read(`VTP_CSR_HITS, hits);
        csr_read(`VTP_CSR_MISSES, misses);
        csr_read(`VTP_CSR_ERRORS, data);
        check_value("ERRORS", data, invalid_count);
        check_value("MISSES", misses, distinct_total + invalid_count);
        check_value("HITS plus MISSES", hits + misses, l2_count);

        afail = dut_i.asserts_i.fail_count;
        $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
                 checks, errors, afail);
        if (errors == 0 && afail == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// ==== vtp_csr.sv ====
// CSR register file with page table root, saturating event counters and flush command
`timescale 1ns/1ns
`include "vtp_settings.svh"

module vtp_csr (
    input  logic clk,
    input  logic rst_n,
    input  logic csr_wr_en,
    input  logic csr_rd_en,
    input  logic [`VTP_CSR_IDX_BITS-1:0] csr_idx,
    input  logic [`VTP_CSR_DATA_BITS-1:0] csr_wr_data,
    input  logic hit_event,
    input  logic miss_event,
    input  logic error_event,
    output logic csr_rd_valid,
    output logic [`VTP_CSR_DATA_BITS-1:0] csr_rd_data,
    output vtp_pkg::pt_addr_t pt_root,
    output logic flush
);

    // Statistics counters, each sticks at its maximum value
    logic [`VTP_CSR_DATA_BITS-1:0] hits;
    logic [`VTP_CSR_DATA_BITS-1:0] misses;
    logic [`VTP_CSR_DATA_BITS-1:0] errors;

    // Read data selected in the request cycle
    logic [`VTP_CSR_DATA_BITS-1:0] rd_mux;

    always_comb
    begin
        // Unknown indices and the command register read as zero
        rd_mux = '0;
        case (csr_idx)
            `VTP_CSR_ID: rd_mux = `VTP_ID_VALUE;
            `VTP_CSR_ROOT: rd_mux = `VTP_CSR_DATA_BITS'(pt_root);
            `VTP_CSR_HITS: rd_mux = hits;
            `VTP_CSR_MISSES: rd_mux = misses;
            `VTP_CSR_ERRORS: rd_mux = errors;
            default: rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            csr_rd_valid <= 1'b0;
            pt_root <= '0;
            flush <= 1'b0;
            hits <= '0;
            misses <= '0;
            errors <= '0;
        end
        else
        begin
            // Reads answer exactly one cycle after the request
            csr_rd_valid <= csr_rd_en;

            // The flush is a single cycle pulse to every cache
            flush <= csr_wr_en && (csr_idx == `VTP_CSR_CTRL) && csr_wr_data[0];

            if (csr_wr_en && (csr_idx == `VTP_CSR_ROOT))
                pt_root <= vtp_pkg::pt_addr_t'(csr_wr_data);

            // Events are counted until the counter is all ones
            if (hit_event && !(&hits))
                hits <= hits + 1'b1;
            if (miss_event && !(&misses))
                misses <= misses + 1'b1;
            if (error_event && !(&errors))
                errors <= errors + 1'b1;
        end
    end

    // Read data is only meaningful while csr_rd_valid is high
    always_ff @(posedge clk)
    begin
        if (csr_rd_en)
            csr_rd_data <= rd_mux;
    end

endmodule

// ==== vtp_l1.sv ====
// Per-port direct-mapped L1 translation cache with client request and response logic
`timescale 1ns/1ns
`include "vtp_settings.svh"

module vtp_l1 (
    input  logic clk,
    input  logic rst_n,
    input  logic flush,
    input  logic req_valid,
    input  vtp_pkg::vpn_t req_vpn,
    input  logic l2_rsp,
    input  vtp_pkg::ppn_t l2_ppn,
    input  logic l2_error,
    output logic busy,
    output logic rsp_valid,
    output vtp_pkg::ppn_t rsp_ppn,
    output logic rsp_error,
    output logic l2_req,
    output vtp_pkg::vpn_t l2_vpn
);

    localparam int IDX_W = $clog2(`VTP_L1_ENTRIES);
    localparam int TAG_W = `VTP_VPN_BITS - IDX_W;

    // Cache arrays, the low VPN bits select the entry and the rest is the tag
    logic [`VTP_L1_ENTRIES-1:0] valid;
    logic [TAG_W-1:0] tag [`VTP_L1_ENTRIES];
    vtp_pkg::ppn_t ppn [`VTP_L1_ENTRIES];

    logic [IDX_W-1:0] req_idx;
    logic [IDX_W-1:0] fill_idx;
    logic req_hit;

    assign req_idx = req_vpn[IDX_W-1:0];
    assign req_hit = valid[req_idx] && (tag[req_idx] == req_vpn[`VTP_VPN_BITS-1:IDX_W]);

    // A fill goes to the slot of the VPN that is waiting on L2
    assign fill_idx = l2_vpn[IDX_W-1:0];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid <= '0;
            busy <= 1'b0;
            rsp_valid <= 1'b0;
            l2_req <= 1'b0;
        end
        else
        begin
            rsp_valid <= 1'b0;

            // Busy covers the response cycle and drops right after it
            if (rsp_valid)
                busy <= 1'b0;

            if (req_valid)
            begin
                busy <= 1'b1;
                // A hit answers next cycle, a miss is handed to L2
                if (req_hit)
                    rsp_valid <= 1'b1;
                else
                    l2_req <= 1'b1;
            end

            // The L2 answer ends the miss and goes straight to the client
            if (l2_rsp)
            begin
                l2_req <= 1'b0;
                rsp_valid <= 1'b1;
                if (!l2_error)
                    valid[fill_idx] <= 1'b1;
            end

            // Flush only comes when the port is idle, so no fill can race it
            if (flush)
                valid <= '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_valid)
        begin
            rsp_ppn <= ppn[req_idx];
            rsp_error <= 1'b0;
            // The VPN is kept stable for the whole L2 request
            if (!req_hit)
                l2_vpn <= req_vpn;
        end

        if (l2_rsp)
        begin
            rsp_ppn <= l2_ppn;
            rsp_error <= l2_error;
            // Failed translations are never cached
            if (!l2_error)
            begin
                tag[fill_idx] <= l2_vpn[`VTP_VPN_BITS-1:IDX_W];
                ppn[fill_idx] <= l2_ppn;
            end
        end
    end

endmodule

// ==== vtp_l2.sv ====
// Round-robin arbiter over L1 misses, fully associative L2 TLB and walk request logic
`timescale 1ns/1ns
`include "vtp_settings.svh"

module vtp_l2 (
    input  logic clk,
    input  logic rst_n,
    input  logic flush,
    input  logic [`VTP_N_PORTS-1:0] l2_req,
    input  vtp_pkg::vpn_t l2_vpn [`VTP_N_PORTS],
    input  logic walk_done,
    input  vtp_pkg::ppn_t walk_ppn,
    input  logic walk_error,
    output logic [`VTP_N_PORTS-1:0] l2_rsp,
    output vtp_pkg::ppn_t l2_ppn,
    output logic l2_error,
    output logic walk_start,
    output vtp_pkg::vpn_t walk_vpn,
    output logic hit_event,
    output logic miss_event
);

    localparam int N = `VTP_N_PORTS;
    localparam int PW = (N > 1) ? $clog2(N) : 1;
    localparam int EW = $clog2(`VTP_L2_ENTRIES);

    typedef enum logic [1:0] {IDLE, LOOKUP, WALK} state_t;

    state_t state;
    // The port being served, also the start point of the next search
    logic [PW-1:0] last_grant;
    vtp_pkg::vpn_t cur_vpn;
    logic [EW-1:0] victim;

    // TLB arrays, any entry may hold any VPN
    logic [`VTP_L2_ENTRIES-1:0] valid;
    vtp_pkg::vpn_t tag [`VTP_L2_ENTRIES];
    vtp_pkg::ppn_t ppn [`VTP_L2_ENTRIES];

    logic [N-1:0] req_eff;
    logic arb_found;
    logic [PW-1:0] arb_port;
    logic lk_hit;
    vtp_pkg::ppn_t lk_ppn;

    // A port whose answer is on the wire this cycle still holds l2_req, mask it
    assign req_eff = l2_req & ~l2_rsp;

    always_comb
    begin
        int cand;
        // Search starts at the port after the last one served
        arb_found = 1'b0;
        arb_port = last_grant;
        for (int i = 1; i <= N; i++)
        begin
            cand = (int'(last_grant) + i) % N;
            if (!arb_found && req_eff[cand])
            begin
                arb_found = 1'b1;
                arb_port = PW'(cand);
            end
        end
    end

    // All tags are compared at once against the granted VPN
    always_comb
    begin
        lk_hit = 1'b0;
        lk_ppn = '0;
        for (int e = 0; e < `VTP_L2_ENTRIES; e++)
        begin
            if (valid[e] && (tag[e] == cur_vpn))
            begin
                lk_hit = 1'b1;
                lk_ppn = ppn[e];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= IDLE;
            last_grant <= '0;
            valid <= '0;
            victim <= '0;
            l2_rsp <= '0;
            walk_start <= 1'b0;
            hit_event <= 1'b0;
            miss_event <= 1'b0;
        end
        else
        begin
            l2_rsp <= '0;
            walk_start <= 1'b0;
            hit_event <= 1'b0;
            miss_event <= 1'b0;

            case (state)
                IDLE:
                begin
                    if (arb_found)
                    begin
                        last_grant <= arb_port;
                        cur_vpn <= l2_vpn[arb_port];
                        state <= LOOKUP;
                    end
                end
                LOOKUP:
                begin
                    // A hit answers two cycles after the grant
                    if (lk_hit)
                    begin
                        l2_rsp[last_grant] <= 1'b1;
                        l2_ppn <= lk_ppn;
                        l2_error <= 1'b0;
                        hit_event <= 1'b1;
                        state <= IDLE;
                    end
                    else
                    begin
                        walk_start <= 1'b1;
                        walk_vpn <= cur_vpn;
                        miss_event <= 1'b1;
                        state <= WALK;
                    end
                end
                WALK:
                begin
                    if (walk_done)
                    begin
                        l2_rsp[last_grant] <= 1'b1;
                        l2_ppn <= walk_ppn;
                        l2_error <= walk_error;
                        // Good results replace the round-robin victim
                        if (!walk_error)
                        begin
                            valid[victim] <= 1'b1;
                            tag[victim] <= cur_vpn;
                            ppn[victim] <= walk_ppn;
                            victim <= victim + 1'b1;
                        end
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase

            if (flush)
                valid <= '0;
        end
    end

endmodule

// ==== vtp_pkg.sv ====
// Address types and the page table entry union shared by the translation service
`include "vtp_settings.svh"

package vtp_pkg;

    typedef logic [`VTP_VPN_BITS-1:0] vpn_t;
    typedef logic [`VTP_PPN_BITS-1:0] ppn_t;
    typedef logic [`VTP_ADDR_BITS-1:0] pt_addr_t;

    // Directory view, points at the next level table
    typedef struct packed {
        logic [`VTP_PTE_BITS-`VTP_ADDR_BITS-3:0] rsvd;
        pt_addr_t next;
        logic leaf;
        logic valid;
    } pte_dir_t;

    // Leaf view, holds the physical page number
    typedef struct packed {
        logic [`VTP_PTE_BITS-`VTP_PPN_BITS-3:0] rsvd;
        ppn_t ppn;
        logic leaf;
        logic valid;
    } pte_leaf_t;

    // The valid and leaf bits sit at the same place in both views,
    // so either view can be used to classify an entry
    typedef union packed {
        pte_dir_t dir;
        pte_leaf_t leaf;
    } pte_u;

endpackage

// ==== vtp_pt_walk.sv ====
// Two-level page table walker issuing host memory reads
`timescale 1ns/1ns
`include "vtp_settings.svh"

module vtp_pt_walk (
    input  logic clk,
    input  logic rst_n,
    input  vtp_pkg::pt_addr_t pt_root,
    input  logic walk_start,
    input  vtp_pkg::vpn_t walk_vpn,
    input  logic mem_rd_valid,
    input  logic [`VTP_PTE_BITS-1:0] mem_rd_data,
    output logic mem_rd_en,
    output vtp_pkg::pt_addr_t mem_rd_addr,
    output logic walk_done,
    output vtp_pkg::ppn_t walk_ppn,
    output logic walk_error,
    output logic error_event
);

    typedef enum logic [1:0] {IDLE, WAIT_L1, WAIT_L2} state_t;

    state_t state;
    vtp_pkg::vpn_t vpn_q;
    vtp_pkg::pte_u pte;
    logic [`VTP_IDX_BITS-1:0] idx_hi;
    logic [`VTP_IDX_BITS-1:0] idx_lo;

    // Entries are eight bytes, so each index is scaled by eight
    assign pte = mem_rd_data;
    assign idx_hi = walk_vpn[`VTP_VPN_BITS-1:`VTP_IDX_BITS];
    assign idx_lo = vpn_q[`VTP_IDX_BITS-1:0];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= IDLE;
            mem_rd_en <= 1'b0;
            walk_done <= 1'b0;
            error_event <= 1'b0;
        end
        else
        begin
            mem_rd_en <= 1'b0;
            walk_done <= 1'b0;
            error_event <= 1'b0;

            case (state)
                IDLE:
                begin
                    if (walk_start)
                    begin
                        vpn_q <= walk_vpn;
                        mem_rd_en <= 1'b1;
                        mem_rd_addr <= pt_root + vtp_pkg::pt_addr_t'({idx_hi, 3'b000});
                        state <= WAIT_L1;
                    end
                end
                WAIT_L1:
                begin
                    if (mem_rd_valid)
                    begin
                        if (!pte.dir.valid)
                        begin
                            walk_done <= 1'b1;
                            walk_error <= 1'b1;
                            error_event <= 1'b1;
                            state <= IDLE;
                        end
                        else if (pte.dir.leaf)
                        begin
                            // Huge page, the low PPN bits come from the level-2 index
                            walk_done <= 1'b1;
                            walk_error <= 1'b0;
                            walk_ppn <= {pte.leaf.ppn[`VTP_PPN_BITS-1:`VTP_IDX_BITS], idx_lo};
                            state <= IDLE;
                        end
                        else
                        begin
                            mem_rd_en <= 1'b1;
                            mem_rd_addr <= pte.dir.next + vtp_pkg::pt_addr_t'({idx_lo, 3'b000});
                            state <= WAIT_L2;
                        end
                    end
                end
                WAIT_L2:
                begin
                    if (mem_rd_valid)
                    begin
                        // There is no third level, so a directory here is also invalid
                        walk_done <= 1'b1;
                        walk_ppn <= pte.leaf.ppn;
                        walk_error <= !(pte.leaf.valid && pte.leaf.leaf);
                        error_event <= !(pte.leaf.valid && pte.leaf.leaf);
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== vtp_settings.svh ====
// Address widths, cache sizes, port count and CSR indices of the translation service
`ifndef VTP_SETTINGS_SVH
`define VTP_SETTINGS_SVH

// Virtual page number, split into two page table indices
`define VTP_VPN_BITS 16
`define VTP_IDX_BITS 8
`define VTP_PPN_BITS 20
`define VTP_ADDR_BITS 32

// One page table entry is a 64-bit host memory word
`define VTP_PTE_BITS 64

// Client ports and cache geometry, entry counts are powers of two
`define VTP_N_PORTS 2
`define VTP_L1_ENTRIES 4
`define VTP_L2_ENTRIES 16

// CSR bus geometry and register map
`define VTP_CSR_IDX_BITS 3
`define VTP_CSR_DATA_BITS 32
`define VTP_CSR_ID 3'd0
`define VTP_CSR_ROOT 3'd1
`define VTP_CSR_CTRL 3'd2
`define VTP_CSR_HITS 3'd3
`define VTP_CSR_MISSES 3'd4
`define VTP_CSR_ERRORS 3'd5
`define VTP_ID_VALUE 32'h5654_5001

`endif

// ==== vtp_svc.f ====
+incdir+.
vtp_pkg.sv
vtp_csr.sv
vtp_l1.sv
vtp_l2.sv
vtp_pt_walk.sv
vtp_svc.sv
tb_clk_gen.sv
vtp_svc_asserts.sv
tb_vtp_svc.sv

// ==== vtp_svc.sv ====
// Top level of the translation service with CSR block, per-port L1 caches, L2 and walker
`timescale 1ns/1ns
`include "vtp_settings.svh"

module vtp_svc (
    input  logic clk,
    input  logic rst_n,
    input  logic [`VTP_N_PORTS-1:0] req_valid,
    input  vtp_pkg::vpn_t req_vpn [`VTP_N_PORTS],
    output logic [`VTP_N_PORTS-1:0] busy,
    output logic [`VTP_N_PORTS-1:0] rsp_valid,
    output vtp_pkg::ppn_t rsp_ppn [`VTP_N_PORTS],
    output logic [`VTP_N_PORTS-1:0] rsp_error,
    output logic mem_rd_en,
    output vtp_pkg::pt_addr_t mem_rd_addr,
    input  logic mem_rd_valid,
    input  logic [`VTP_PTE_BITS-1:0] mem_rd_data,
    input  logic csr_wr_en,
    input  logic csr_rd_en,
    input  logic [`VTP_CSR_IDX_BITS-1:0] csr_idx,
    input  logic [`VTP_CSR_DATA_BITS-1:0] csr_wr_data,
    output logic csr_rd_valid,
    output logic [`VTP_CSR_DATA_BITS-1:0] csr_rd_data
);

    // Miss path between the L1 caches and the shared L2
    logic [`VTP_N_PORTS-1:0] l2_req;
    vtp_pkg::vpn_t l2_vpn [`VTP_N_PORTS];
    logic [`VTP_N_PORTS-1:0] l2_rsp;
    vtp_pkg::ppn_t l2_ppn;
    logic l2_error;

    // Walk request path and CSR side signals
    logic walk_start;
    vtp_pkg::vpn_t walk_vpn;
    logic walk_done;
    vtp_pkg::ppn_t walk_ppn;
    logic walk_error;
    logic hit_event;
    logic miss_event;
    logic error_event;
    vtp_pkg::pt_addr_t pt_root;
    logic flush;

    vtp_csr csr_i (
        .clk, .rst_n, .csr_wr_en, .csr_rd_en, .csr_idx, .csr_wr_data,
        .hit_event, .miss_event, .error_event,
        .csr_rd_valid, .csr_rd_data, .pt_root, .flush
    );

    // Each client owns a private L1, the answer from L2 is shared and qualified per port
    for (genvar p = 0; p < `VTP_N_PORTS; p++)
    begin : g_port
        vtp_l1 l1_i (
            .clk, .rst_n, .flush,
            .req_valid(req_valid[p]), .req_vpn(req_vpn[p]),
            .l2_rsp(l2_rsp[p]), .l2_ppn, .l2_error,
            .busy(busy[p]), .rsp_valid(rsp_valid[p]),
            .rsp_ppn(rsp_ppn[p]), .rsp_error(rsp_error[p]),
            .l2_req(l2_req[p]), .l2_vpn(l2_vpn[p])
        );
    end

    vtp_l2 l2_i (
        .clk, .rst_n, .flush, .l2_req, .l2_vpn,
        .walk_done, .walk_ppn, .walk_error,
        .l2_rsp, .l2_ppn, .l2_error, .walk_start, .walk_vpn,
        .hit_event, .miss_event
    );

    vtp_pt_walk walk_i (
        .clk, .rst_n, .pt_root, .walk_start, .walk_vpn,
        .mem_rd_valid, .mem_rd_data,
        .mem_rd_en, .mem_rd_addr, .walk_done, .walk_ppn, .walk_error, .error_event
    );

endmodule

// ==== vtp_svc_asserts.sv ====
// Concurrent protocol assertions for the translation service top level
`timescale 1ns/1ns
`include "vtp_settings.svh"

module vtp_svc_asserts (
    input logic clk,
    input logic rst_n,
    input logic [`VTP_N_PORTS-1:0] req_valid,
    input logic [`VTP_N_PORTS-1:0] busy,
    input logic [`VTP_N_PORTS-1:0] rsp_valid,
    input logic mem_rd_en,
    input logic mem_rd_valid,
    input logic csr_rd_en,
    input logic csr_rd_valid
);

    // Number of failed assertions, read by the testbench at the end of the run
    int fail_count = 0;

    // One bit per port that has a request in flight
    logic [`VTP_N_PORTS-1:0] pending;
    // High while a host memory read waits for its data
    logic rd_pending;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pending <= '0;
            rd_pending <= 1'b0;
        end
        else
        begin
            pending <= (pending | req_valid) & ~rsp_valid;
            if (mem_rd_en)
                rd_pending <= 1'b1;
            else if (mem_rd_valid)
                rd_pending <= 1'b0;
        end
    end

    // A client may not request while its port is busy
    no_req_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid & busy) == '0)
    else
    begin
        fail_count++;
        $error("Request pulsed while the port was busy");
    end

    // Every response belongs to an earlier request on the same port
    rsp_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp_valid & ~pending) == '0)
    else
    begin
        fail_count++;
        $error("Response without a request in flight");
    end

    // The walker keeps at most one memory read outstanding
    one_mem_read: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rd_en |-> !rd_pending)
    else
    begin
        fail_count++;
        $error("Memory read issued while another read was outstanding");
    end

    // CSR reads answer exactly one cycle after the request and never otherwise
    csr_rd_follows: assert property (@(posedge clk) disable iff (!rst_n)
        csr_rd_en |=> csr_rd_valid)
    else
    begin
        fail_count++;
        $error("CSR read data did not follow the read request");
    end

    csr_rd_has_req: assert property (@(posedge clk) disable iff (!rst_n)
        csr_rd_valid |-> $past(csr_rd_en))
    else
    begin
        fail_count++;
        $error("CSR read data without a read request");
    end

endmodule
